//--- hw/rvCore_config.svh
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// datapath and register index widths
`define RV_XLEN        32
`define RV_REG_IDX_W   5

// first fetch address after reset
`define RV_PC_RESET    32'h0000_0000

// data memory size in words, and the matching word index width
`define RV_DMEM_WORDS  256
`define RV_DMEM_ADDR_W 8

// addi x0, x0, 0
`define RV_NOP         32'h0000_0013

// ebreak, full word match
`define RV_EBREAK      32'h0010_0073

`endif

//--- hw/rvCorePkg.sv
`default_nettype none

`include "rvCore_config.svh"

package rvCorePkg;

  typedef logic [`RV_XLEN-1:0]      word_t;
  typedef logic [`RV_REG_IDX_W-1:0] regIdx_t;

  // alu function select
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt,
    aluPassB,
    aluEq
  } aluOp_t;

  // per-instruction control bits from the decoder
  typedef struct packed {
    logic regWen;
    logic memWen;
    logic isLoad;
    logic isBranch;
    logic branchNe;
    logic isJal;
    logic isEbreak;
    logic useImm;
  } ctrlSig_t;

  // opA/opB hold register values after ID forwarding
  typedef struct packed {
    logic     valid;
    word_t    pc;
    regIdx_t  rd;
    regIdx_t  rs1;
    regIdx_t  rs2;
    word_t    opA;
    word_t    opB;
    word_t    imm;
    aluOp_t   aluOp;
    ctrlSig_t ctrl;
  } idEx_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    regIdx_t  rd;
    word_t    aluResult;
    word_t    storeData;
    ctrlSig_t ctrl;
  } exMem_t;

  // data is 0 when the instruction writes no register
  typedef struct packed {
    logic    valid;
    word_t   pc;
    regIdx_t rd;
    word_t   data;
  } retire_t;

  typedef enum logic [1:0] {
    sRun,
    sDrain,
    sHalted
  } runState_t;

endpackage

`default_nettype wire

//--- hw/instDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_config.svh"

module instDecoder (
  input  rvCorePkg::word_t    inst,
  output rvCorePkg::regIdx_t  rd,
  output rvCorePkg::regIdx_t  rs1,
  output rvCorePkg::regIdx_t  rs2,
  output rvCorePkg::word_t    imm,
  output rvCorePkg::aluOp_t   aluOp,
  output rvCorePkg::ctrlSig_t ctrl
);
  import rvCorePkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // unused indices stay 0 so they never trigger forwarding
  always_comb begin
    rd    = '0;
    rs1   = '0;
    rs2   = '0;
    imm   = '0;
    aluOp = aluAdd;
    ctrl  = '0;
    case (opcode)
      // register-register ops
      7'b0110011: begin
        rd          = inst[11:7];
        rs1         = inst[19:15];
        rs2         = inst[24:20];
        ctrl.regWen = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: aluOp = aluAdd;
          10'b0100000_000: aluOp = aluSub;
          10'b0000000_111: aluOp = aluAnd;
          10'b0000000_110: aluOp = aluOr;
          10'b0000000_100: aluOp = aluXor;
          10'b0000000_010: aluOp = aluSlt;
          default: begin
            rd          = '0;
            rs1         = '0;
            rs2         = '0;
            ctrl.regWen = 1'b0;
          end
        endcase
      end
      // addi
      7'b0010011: begin
        if (funct3 == 3'b000) begin
          rd          = inst[11:7];
          rs1         = inst[19:15];
          imm         = {{20{inst[31]}}, inst[31:20]};
          ctrl.regWen = 1'b1;
          ctrl.useImm = 1'b1;
        end
      end
      // lui, immediate goes straight through
      7'b0110111: begin
        rd          = inst[11:7];
        imm         = {inst[31:12], 12'b0};
        aluOp       = aluPassB;
        ctrl.regWen = 1'b1;
        ctrl.useImm = 1'b1;
      end
      // lw
      7'b0000011: begin
        if (funct3 == 3'b010) begin
          rd          = inst[11:7];
          rs1         = inst[19:15];
          imm         = {{20{inst[31]}}, inst[31:20]};
          ctrl.regWen = 1'b1;
          ctrl.isLoad = 1'b1;
          ctrl.useImm = 1'b1;
        end
      end
      // sw
      7'b0100011: begin
        if (funct3 == 3'b010) begin
          rs1         = inst[19:15];
          rs2         = inst[24:20];
          imm         = {{20{inst[31]}}, inst[31:25], inst[11:7]};
          ctrl.memWen = 1'b1;
          ctrl.useImm = 1'b1;
        end
      end
      // beq / bne compare in the alu
      7'b1100011: begin
        if (funct3 == 3'b000 || funct3 == 3'b001) begin
          rs1           = inst[19:15];
          rs2           = inst[24:20];
          imm           = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
          aluOp         = aluEq;
          ctrl.isBranch = 1'b1;
          ctrl.branchNe = funct3[0];
        end
      end
      // jal, link value is supplied by the ID stage
      7'b1101111: begin
        rd          = inst[11:7];
        imm         = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        aluOp       = aluPassB;
        ctrl.regWen = 1'b1;
        ctrl.isJal  = 1'b1;
      end
      7'b1110011: begin
        ctrl.isEbreak = (inst == `RV_EBREAK);
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hw/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
  input  logic               clk,
  input  logic               wen,
  input  rvCorePkg::regIdx_t waddr,
  input  rvCorePkg::word_t   wdata,
  input  rvCorePkg::regIdx_t raddrA,
  input  rvCorePkg::regIdx_t raddrB,
  output rvCorePkg::word_t   rdataA,
  output rvCorePkg::word_t   rdataB
);
  import rvCorePkg::*;

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // write-through so a same-cycle writeback is seen by the reader
  assign rdataA = (raddrA == '0)                 ? '0    :
                  (wen && waddr == raddrA)       ? wdata :
                                                   regs[raddrA];
  assign rdataB = (raddrB == '0)                 ? '0    :
                  (wen && waddr == raddrB)       ? wdata :
                                                   regs[raddrB];

endmodule

`default_nettype wire

//--- hw/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
  input  rvCorePkg::word_t  opA,
  input  rvCorePkg::word_t  opB,
  input  rvCorePkg::aluOp_t aluOp,
  output rvCorePkg::word_t  result
);
  import rvCorePkg::*;

  always_comb begin
    case (aluOp)
      aluAdd:   result = opA + opB;
      aluSub:   result = opA - opB;
      aluAnd:   result = opA & opB;
      aluOr:    result = opA | opB;
      aluXor:   result = opA ^ opB;
      // signed compare, flag in bit 0
      aluSlt:   result = {31'b0, $signed(opA) < $signed(opB)};
      aluPassB: result = opB;
      aluEq:    result = {31'b0, opA == opB};
      default:  result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/dataMemory.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_config.svh"

module dataMemory (
  input  logic             clk,
  input  logic             wen,
  input  rvCorePkg::word_t addr,
  input  rvCorePkg::word_t wdata,
  output rvCorePkg::word_t rdata
);
  import rvCorePkg::*;

  word_t                      mem [`RV_DMEM_WORDS];
  logic [`RV_DMEM_ADDR_W-1:0] wordIdx;

  // byte address to word index, low two bits ignored
  assign wordIdx = addr[`RV_DMEM_ADDR_W+1:2];

  always_ff @(posedge clk) begin
    if (wen) begin
      mem[wordIdx] <= wdata;
    end
  end

  // combinational read for the load-to-use path
  assign rdata = mem[wordIdx];

endmodule

`default_nettype wire

//--- hw/programCounter.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_config.svh"

module programCounter (
  input  logic             clk,
  input  logic             arstN,
  input  logic             advance,
  input  logic             redirect,
  input  rvCorePkg::word_t target,
  output rvCorePkg::word_t pc
);
  import rvCorePkg::*;

  word_t pcNext;

  // redirect beats sequential step
  always_comb begin
    if (redirect) begin
      pcNext = target;
    end else if (advance) begin
      pcNext = pc + 32'd4;
    end else begin
      pcNext = pc;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc <= `RV_PC_RESET;
    end else begin
      pc <= pcNext;
    end
  end

endmodule

`default_nettype wire

//--- hw/runControl.sv
`timescale 1ns/1ps
`default_nettype none

module runControl (
  input  logic clk,
  input  logic arstN,
  input  logic ebreakInMem,
  output logic fetchEnable,
  output logic flushAll,
  output logic halted
);
  import rvCorePkg::*;

  runState_t state;
  runState_t stateNext;

  always_comb begin
    stateNext = state;
    case (state)
      sRun:    if (ebreakInMem) stateNext = sDrain;
      sDrain:  stateNext = sHalted;
      sHalted: stateNext = sHalted;
      default: stateNext = sHalted;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= sRun;
    end else begin
      state <= stateNext;
    end
  end

  // squash everything younger than the ebreak from the cycle it hits MEM
  assign flushAll    = (state != sRun) || ebreakInMem;
  assign fetchEnable = !flushAll;
  assign halted      = (state == sHalted);

endmodule

`default_nettype wire

//--- hw/rvCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_config.svh"

module rvCore (
  input  logic               clk,
  input  logic               arstN,
  input  rvCorePkg::word_t   imemData,
  output rvCorePkg::word_t   imemAddr,
  output rvCorePkg::retire_t retire,
  output logic               halted
);
  import rvCorePkg::*;

  word_t    pc;
  logic     fetchEnable;
  logic     flushAll;
  logic     ebreakInMem;
  logic     ifIdValid;
  word_t    ifIdPc;
  word_t    ifIdInst;
  regIdx_t  idRd;
  regIdx_t  idRs1;
  regIdx_t  idRs2;
  word_t    idImm;
  aluOp_t   idAluOp;
  ctrlSig_t idCtrl;
  word_t    rfDataA;
  word_t    rfDataB;
  word_t    fwdA;
  word_t    fwdB;
  word_t    jalLink;
  idEx_t    idEx;
  idEx_t    idExNext;
  exMem_t   exMem;
  exMem_t   exMemNext;
  word_t    exOpA;
  word_t    exOpB;
  word_t    aluB;
  word_t    aluResult;
  word_t    memRdata;
  word_t    wbData;
  logic     wbEn;
  logic     exFwdHit;
  logic     memFwdHit;
  logic     memLoadHit;
  logic     branchTaken;
  logic     jalTaken;
  logic     redirect;
  word_t    target;
  logic     flushIfId;
  logic     flushIdEx;
  retire_t  retireReg;

  programCounter u_programCounter (
    .clk      (clk),
    .arstN    (arstN),
    .advance  (fetchEnable),
    .redirect (redirect),
    .target   (target),
    .pc       (pc)
  );

  runControl u_runControl (
    .clk         (clk),
    .arstN       (arstN),
    .ebreakInMem (ebreakInMem),
    .fetchEnable (fetchEnable),
    .flushAll    (flushAll),
    .halted      (halted)
  );

  assign imemAddr = pc;

  // IF/ID, flushed slots carry a NOP
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ifIdValid <= 1'b0;
      ifIdPc    <= `RV_PC_RESET;
      ifIdInst  <= `RV_NOP;
    end else begin
      ifIdValid <= fetchEnable && !flushIfId;
      ifIdPc    <= pc;
      ifIdInst  <= (flushIfId || !fetchEnable) ? `RV_NOP : imemData;
    end
  end

  instDecoder u_instDecoder (
    .inst  (ifIdInst),
    .rd    (idRd),
    .rs1   (idRs1),
    .rs2   (idRs2),
    .imm   (idImm),
    .aluOp (idAluOp),
    .ctrl  (idCtrl)
  );

  registerFile u_registerFile (
    .clk    (clk),
    .wen    (wbEn),
    .waddr  (exMem.rd),
    .wdata  (wbData),
    .raddrA (idRs1),
    .raddrB (idRs2),
    .rdataA (rfDataA),
    .rdataB (rfDataB)
  );

  // loads in EX have no data yet, they are caught later in EX
  assign exFwdHit  = idEx.valid && idEx.ctrl.regWen && !idEx.ctrl.isLoad && idEx.rd != '0;
  assign memFwdHit = exMem.valid && exMem.ctrl.regWen && exMem.rd != '0;

  assign fwdA = (exFwdHit && idEx.rd == idRs1)   ? aluResult :
                (memFwdHit && exMem.rd == idRs1) ? wbData    :
                                                   rfDataA;
  assign fwdB = (exFwdHit && idEx.rd == idRs2)   ? aluResult :
                (memFwdHit && exMem.rd == idRs2) ? wbData    :
                                                   rfDataB;

  // jal link rides both operands so passB returns it
  assign jalLink = ifIdPc + 32'd4;

  always_comb begin
    idExNext.valid = ifIdValid && !flushIdEx;
    idExNext.pc    = ifIdPc;
    idExNext.rd    = idRd;
    idExNext.rs1   = idRs1;
    idExNext.rs2   = idRs2;
    idExNext.opA   = idCtrl.isJal ? jalLink : fwdA;
    idExNext.opB   = idCtrl.isJal ? jalLink : fwdB;
    idExNext.imm   = idImm;
    idExNext.aluOp = idAluOp;
    idExNext.ctrl  = idCtrl;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      idEx <= '0;
    end else begin
      idEx <= idExNext;
    end
  end

  // load result in MEM overrides the stale EX operand
  assign memLoadHit = exMem.valid && exMem.ctrl.isLoad && exMem.rd != '0;
  assign exOpA = (memLoadHit && exMem.rd == idEx.rs1) ? memRdata : idEx.opA;
  assign exOpB = (memLoadHit && exMem.rd == idEx.rs2) ? memRdata : idEx.opB;
  assign aluB  = idEx.ctrl.useImm ? idEx.imm : exOpB;

  aluUnit u_aluUnit (
    .opA    (exOpA),
    .opB    (aluB),
    .aluOp  (idEx.aluOp),
    .result (aluResult)
  );

  // redirects, older branch in EX wins over jal in ID
  assign branchTaken = idEx.valid && idEx.ctrl.isBranch && !flushAll &&
                       (aluResult[0] ^ idEx.ctrl.branchNe);
  assign jalTaken    = ifIdValid && idCtrl.isJal && !flushAll;
  assign redirect    = branchTaken || jalTaken;
  assign target      = branchTaken ? (idEx.pc + idEx.imm) : (ifIdPc + idImm);
  assign flushIfId   = redirect || flushAll;
  assign flushIdEx   = branchTaken || flushAll;

  always_comb begin
    exMemNext.valid     = idEx.valid && !flushAll;
    exMemNext.pc        = idEx.pc;
    exMemNext.rd        = idEx.rd;
    exMemNext.aluResult = aluResult;
    exMemNext.storeData = exOpB;
    exMemNext.ctrl      = idEx.ctrl;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      exMem <= '0;
    end else begin
      exMem <= exMemNext;
    end
  end

  dataMemory u_dataMemory (
    .clk   (clk),
    .wen   (exMem.valid && exMem.ctrl.memWen),
    .addr  (exMem.aluResult),
    .wdata (exMem.storeData),
    .rdata (memRdata)
  );

  // writeback happens at the end of MEM
  assign wbData      = exMem.ctrl.isLoad ? memRdata : exMem.aluResult;
  assign wbEn        = exMem.valid && exMem.ctrl.regWen;
  assign ebreakInMem = exMem.valid && exMem.ctrl.isEbreak;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      retireReg <= '0;
    end else begin
      retireReg.valid <= exMem.valid;
      retireReg.pc    <= exMem.pc;
      retireReg.rd    <= exMem.rd;
      retireReg.data  <= (wbEn && exMem.rd != '0) ? wbData : '0;
    end
  end

  assign retire = retireReg;

endmodule

`default_nettype wire

//--- verification/rvCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_config.svh"

module rvCoreTb;
  import rvCorePkg::*;

  localparam int progInsts  = 55;
  localparam int numTests   = 6;
  localparam int cycleLimit = progInsts * 4 + numTests * 30 + 100;

  logic    clk;
  logic    arstN;
  word_t   imemData;
  word_t   imemAddr;
  retire_t retire;
  logic    halted;

  word_t       rom [256];
  word_t       regModel [32];
  retire_t     retired [$];
  retire_t     expected [$];
  string       curTest;
  int          errorCount;
  int          testErrorStart;
  int          passCount;
  int          failCount;
  int          cycleCount;
  int unsigned seedVal;

  rvCore i_dut (
    .clk      (clk),
    .arstN    (arstN),
    .imemData (imemData),
    .imemAddr (imemAddr),
    .retire   (retire),
    .halted   (halted)
  );

  // external instruction ROM, answers in the same cycle
  assign imemData = rom[imemAddr[9:2]];

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Simulation stopped: no result after %0d clock cycles", cycleCount);
    $display("TEST FAILED");
    $finish;
  end

  // RV32I encodings
  function automatic word_t addiInst(input regIdx_t rd, input regIdx_t rs1,
                                     input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic word_t luiInst(input regIdx_t rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic word_t lwInst(input regIdx_t rd, input regIdx_t base,
                                   input logic [11:0] off);
    return {off, base, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic word_t swInst(input regIdx_t src, input regIdx_t base,
                                   input logic [11:0] off);
    return {off[11:5], src, base, 3'b010, off[4:0], 7'b0100011};
  endfunction

  function automatic word_t rTypeInst(input logic [6:0] f7, input logic [2:0] f3,
                                      input regIdx_t rd, input regIdx_t rs1,
                                      input regIdx_t rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  // f3 000 is beq, 001 is bne
  function automatic word_t branchInst(input logic [2:0] f3, input regIdx_t rs1,
                                       input regIdx_t rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic word_t jalInst(input regIdx_t rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic word_t lessThan(input word_t a, input word_t b);
    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
  endfunction

  task automatic reportError(input string msg);
    $display("Error at %0t: %s", $time, msg);
    errorCount++;
  endtask

  task automatic checkRetire(input retire_t got, input retire_t exp, input string what);
    if (got !== exp) begin
      reportError($sformatf("%s, got pc %h rd %0d data %h valid %b, expected pc %h rd %0d data %h",
                            what, got.pc, got.rd, got.data, got.valid,
                            exp.pc, exp.rd, exp.data));
    end
  endtask

  task automatic checkWord(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      reportError($sformatf("%s, got %h, expected %h", what, got, exp));
    end
  endtask

  task automatic checkHalted(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      reportError($sformatf("%s, halted %b, expected %b", what, got, exp));
    end
  endtask

  // addi x0, x0, index, so every word differs with the address
  task automatic fillRom();
    int          i;
    logic [11:0] idx;
    for (i = 0; i < 256; i++) begin
      idx    = 12'(i);
      rom[i] = {idx, 13'd0, 7'b0010011};
    end
  endtask

  // records only what the ISA says; writes to x0 report 0
  task automatic expectRetire(input word_t pc, input regIdx_t rd, input word_t data);
    retire_t r;
    r.valid = 1'b1;
    r.pc    = pc;
    r.rd    = rd;
    r.data  = (rd == 5'd0) ? '0 : data;
    expected.push_back(r);
    if (rd != 5'd0) begin
      regModel[rd] = data;
    end
  endtask

  task automatic beginTest(input string name);
    @(posedge clk);
    #2;
    arstN          = 1'b0;
    curTest        = name;
    testErrorStart = errorCount;
    regModel[0]    = '0;
    expected.delete();
    retired.delete();
    fillRom();
  endtask

  task automatic checkResetState(input string when);
    checkWord({31'b0, retire.valid}, '0, {"retire valid ", when});
    checkHalted(halted, 1'b0, {"halted ", when});
    checkWord(imemAddr, `RV_PC_RESET, {"fetch address ", when});
  endtask

  task automatic compareRetires();
    int n;
    int i;
    if (retired.size() != expected.size()) begin
      reportError($sformatf("%0d instructions retired, %0d expected",
                            retired.size(), expected.size()));
    end
    n = (retired.size() < expected.size()) ? retired.size() : expected.size();
    for (i = 0; i < n; i++) begin
      checkRetire(retired[i], expected[i], $sformatf("retire record %0d", i));
    end
  endtask

  // reset, run until EBREAK retires, then watch the halted core
  task automatic runProgram(input word_t ebreakPc);
    logic  haltPending;
    logic  finished;
    word_t heldAddr;
    haltPending = 1'b0;
    finished    = 1'b0;
    repeat (8) begin
      @(negedge clk);
      checkResetState("during reset");
    end
    @(posedge clk);
    #2;
    arstN = 1'b1;
    @(negedge clk);
    checkResetState("after reset");
    while (!finished) begin
      @(negedge clk);
      if (haltPending) begin
        checkHalted(halted, 1'b1, "cycle after EBREAK retired");
        finished = 1'b1;
      end else if (halted) begin
        reportError("core halted before EBREAK retired");
        finished = 1'b1;
      end
      if (retire.valid) begin
        retired.push_back(retire);
        if (retire.pc == ebreakPc && !finished) begin
          haltPending = 1'b1;
        end
      end
    end
    heldAddr = imemAddr;
    repeat (4) begin
      @(negedge clk);
      checkWord(imemAddr, heldAddr, "fetch address while halted");
      checkHalted(halted, 1'b1, "while halted");
      if (retire.valid) begin
        reportError($sformatf("instruction at pc %h retired after halt", retire.pc));
      end
    end
    compareRetires();
    if (errorCount == testErrorStart) begin
      passCount++;
      $display("%s: passed", curTest);
    end else begin
      failCount++;
      $display("%s: failed with %0d errors", curTest, errorCount - testErrorStart);
    end
  endtask

  task automatic testArithChain();
    logic [11:0] immA;
    logic [19:0] immU;
    beginTest("arithmetic chain");
    immA    = 12'($urandom());
    immU    = 20'($urandom());
    rom[0]  = addiInst(5'd1, 5'd0, immA);
    rom[1]  = luiInst(5'd2, immU);
    rom[2]  = rTypeInst(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
    rom[3]  = rTypeInst(7'h20, 3'b000, 5'd4, 5'd3, 5'd1);
    rom[4]  = rTypeInst(7'h00, 3'b111, 5'd5, 5'd4, 5'd3);
    rom[5]  = rTypeInst(7'h00, 3'b110, 5'd6, 5'd5, 5'd4);
    rom[6]  = rTypeInst(7'h00, 3'b100, 5'd7, 5'd6, 5'd5);
    rom[7]  = rTypeInst(7'h00, 3'b010, 5'd8, 5'd7, 5'd6);
    rom[8]  = rTypeInst(7'h00, 3'b010, 5'd9, 5'd6, 5'd7);
    rom[9]  = `RV_EBREAK;
    expectRetire(32'd0, 5'd1, sext12(immA));
    expectRetire(32'd4, 5'd2, {immU, 12'b0});
    expectRetire(32'd8, 5'd3, regModel[1] + regModel[2]);
    expectRetire(32'd12, 5'd4, regModel[3] - regModel[1]);
    expectRetire(32'd16, 5'd5, regModel[4] & regModel[3]);
    expectRetire(32'd20, 5'd6, regModel[5] | regModel[4]);
    expectRetire(32'd24, 5'd7, regModel[6] ^ regModel[5]);
    expectRetire(32'd28, 5'd8, lessThan(regModel[7], regModel[6]));
    expectRetire(32'd32, 5'd9, lessThan(regModel[6], regModel[7]));
    expectRetire(32'd36, 5'd0, '0);
    runProgram(32'd36);
  endtask

  task automatic testStoreLoad();
    logic [19:0] hi2;
    logic [11:0] lo2;
    logic [19:0] hi3;
    logic [11:0] lo3;
    word_t       stored [4];
    beginTest("store and load");
    hi2     = 20'($urandom());
    lo2     = 12'($urandom());
    hi3     = 20'($urandom());
    lo3     = 12'($urandom());
    rom[0]  = addiInst(5'd1, 5'd0, 12'h040);
    rom[1]  = luiInst(5'd2, hi2);
    rom[2]  = addiInst(5'd2, 5'd2, lo2);
    rom[3]  = swInst(5'd2, 5'd1, 12'd0);
    rom[4]  = luiInst(5'd3, hi3);
    rom[5]  = addiInst(5'd3, 5'd3, lo3);
    rom[6]  = swInst(5'd3, 5'd1, 12'd4);
    rom[7]  = swInst(5'd2, 5'd1, 12'd8);
    rom[8]  = lwInst(5'd4, 5'd1, 12'd0);
    rom[9]  = lwInst(5'd5, 5'd1, 12'd4);
    // sum uses the load one slot ahead
    rom[10] = rTypeInst(7'h00, 3'b000, 5'd6, 5'd5, 5'd4);
    rom[11] = lwInst(5'd7, 5'd1, 12'd8);
    rom[12] = swInst(5'd7, 5'd1, 12'd12);
    rom[13] = lwInst(5'd8, 5'd1, 12'd12);
    rom[14] = `RV_EBREAK;
    expectRetire(32'd0, 5'd1, 32'h0000_0040);
    expectRetire(32'd4, 5'd2, {hi2, 12'b0});
    expectRetire(32'd8, 5'd2, regModel[2] + sext12(lo2));
    stored[0] = regModel[2];
    expectRetire(32'd12, 5'd0, '0);
    expectRetire(32'd16, 5'd3, {hi3, 12'b0});
    expectRetire(32'd20, 5'd3, regModel[3] + sext12(lo3));
    stored[1] = regModel[3];
    expectRetire(32'd24, 5'd0, '0);
    stored[2] = regModel[2];
    expectRetire(32'd28, 5'd0, '0);
    expectRetire(32'd32, 5'd4, stored[0]);
    expectRetire(32'd36, 5'd5, stored[1]);
    expectRetire(32'd40, 5'd6, regModel[5] + regModel[4]);
    expectRetire(32'd44, 5'd7, stored[2]);
    stored[3] = regModel[7];
    expectRetire(32'd48, 5'd0, '0);
    expectRetire(32'd52, 5'd8, stored[3]);
    expectRetire(32'd56, 5'd0, '0);
    runProgram(32'd56);
  endtask

  task automatic testBranches();
    beginTest("branches");
    rom[0]  = addiInst(5'd1, 5'd0, 12'd7);
    rom[1]  = addiInst(5'd2, 5'd0, 12'd7);
    // beq taken, 8 + 12 = 20
    rom[2]  = branchInst(3'b000, 5'd1, 5'd2, 13'd12);
    rom[3]  = addiInst(5'd10, 5'd0, 12'd1);
    rom[4]  = addiInst(5'd11, 5'd0, 12'd2);
    rom[5]  = branchInst(3'b001, 5'd1, 5'd2, 13'd8);
    rom[6]  = addiInst(5'd3, 5'd0, 12'd5);
    // bne taken, 28 + 12 = 40
    rom[7]  = branchInst(3'b001, 5'd3, 5'd1, 13'd12);
    rom[8]  = addiInst(5'd12, 5'd0, 12'd3);
    rom[9]  = addiInst(5'd13, 5'd0, 12'd4);
    rom[10] = rTypeInst(7'h00, 3'b000, 5'd4, 5'd3, 5'd1);
    rom[11] = `RV_EBREAK;
    expectRetire(32'd0, 5'd1, 32'd7);
    expectRetire(32'd4, 5'd2, 32'd7);
    expectRetire(32'd8, 5'd0, '0);
    expectRetire(32'd20, 5'd0, '0);
    expectRetire(32'd24, 5'd3, 32'd5);
    expectRetire(32'd28, 5'd0, '0);
    expectRetire(32'd40, 5'd4, regModel[3] + regModel[1]);
    expectRetire(32'd44, 5'd0, '0);
    runProgram(32'd44);
  endtask

  task automatic testJal();
    beginTest("jal");
    rom[0] = addiInst(5'd1, 5'd0, 12'd3);
    rom[1] = jalInst(5'd5, 21'd12);
    rom[2] = addiInst(5'd6, 5'd0, 12'd1);
    rom[3] = addiInst(5'd7, 5'd0, 12'd2);
    rom[4] = rTypeInst(7'h00, 3'b000, 5'd8, 5'd5, 5'd1);
    rom[5] = jalInst(5'd0, 21'd8);
    rom[6] = addiInst(5'd9, 5'd0, 12'd1);
    rom[7] = `RV_EBREAK;
    expectRetire(32'd0, 5'd1, 32'd3);
    // link is the address after the jal
    expectRetire(32'd4, 5'd5, 32'd8);
    expectRetire(32'd16, 5'd8, regModel[5] + regModel[1]);
    expectRetire(32'd20, 5'd0, 32'd24);
    expectRetire(32'd28, 5'd0, '0);
    runProgram(32'd28);
  endtask

  task automatic testEbreak();
    beginTest("ebreak");
    rom[0] = addiInst(5'd1, 5'd0, 12'd11);
    rom[1] = `RV_EBREAK;
    // none of these may retire
    rom[2] = addiInst(5'd1, 5'd0, 12'd22);
    rom[3] = addiInst(5'd2, 5'd0, 12'd33);
    rom[4] = swInst(5'd1, 5'd0, 12'd0);
    expectRetire(32'd0, 5'd1, 32'd11);
    expectRetire(32'd4, 5'd0, '0);
    runProgram(32'd4);
  endtask

  task automatic testResetState();
    logic [19:0] immU;
    beginTest("reset state and x0");
    immU   = 20'($urandom());
    rom[0] = addiInst(5'd0, 5'd0, 12'd100);
    rom[1] = luiInst(5'd0, immU);
    rom[2] = rTypeInst(7'h00, 3'b000, 5'd1, 5'd0, 5'd0);
    rom[3] = addiInst(5'd2, 5'd0, 12'd5);
    rom[4] = `RV_EBREAK;
    expectRetire(32'd0, 5'd0, 32'd100);
    expectRetire(32'd4, 5'd0, {immU, 12'b0});
    expectRetire(32'd8, 5'd1, regModel[0] + regModel[0]);
    expectRetire(32'd12, 5'd2, 32'd5);
    expectRetire(32'd16, 5'd0, '0);
    runProgram(32'd16);
  endtask

  initial begin
    seedVal    = $urandom(85);
    arstN      = 1'b0;
    errorCount = 0;
    passCount  = 0;
    failCount  = 0;
    fillRom();
    testArithChain();
    testStoreLoad();
    testBranches();
    testJal();
    testEbreak();
    testResetState();
    $display("tests passed: %0d, tests failed: %0d", passCount, failCount);
    if (failCount == 0 && errorCount == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+hw
hw/rvCorePkg.sv
hw/instDecoder.sv
hw/registerFile.sv
hw/aluUnit.sv
hw/dataMemory.sv
hw/programCounter.sv
hw/runControl.sv
hw/rvCore.sv
verification/rvCoreTb.sv

//--- Makefile
# Verilator build for the rvCore testbench

VERILATOR ?= verilator
FILELIST  ?= all.f
TOP       ?= rvCoreTb
RTL_TOP   ?= rvCore
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_TEXT ?= TEST OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
